// File: src/awg_dims_pkg.sv
package awg_dims_pkg;

  ////////////////////
  // sizes
  ////////////////////

  // channel count and buffer words per channel
  localparam int num_channels = 2;
  localparam int buffer_depth = 16;

  // one buffer word carries several samples side by side
  localparam int sample_width = 12;
  localparam int parallel_samples = 2;
  localparam int word_width = sample_width * parallel_samples;

  localparam int addr_width = $clog2(buffer_depth);
  // one more bit than the address, so a full depth of 16 fits
  localparam int depth_field_width = addr_width + 1;
  localparam int burst_count_width = 16;

  ////////////////////
  // datapath types
  ////////////////////

  typedef logic [word_width-1:0] sample_word_t;
  typedef logic [addr_width-1:0] buf_addr_t;
  typedef logic [$clog2(num_channels)-1:0] channel_t;
  typedef logic [burst_count_width-1:0] burst_count_t;

endpackage

// File: src/awg_ctrl_pkg.sv
package awg_ctrl_pkg;

  // per channel trigger behaviour during playback
  typedef enum logic [1:0] {
    trig_off = 2'd0,
    trig_burst_start = 2'd1,
    trig_every_frame = 2'd2
  } trigger_mode_t;

  // host side load state machine
  typedef enum logic [1:0] {
    load_idle = 2'd0,
    load_accepting = 2'd1,
    load_blocking = 2'd2
  } load_state_t;

  // transfer status word
  typedef logic [1:0] err_status_t;
  // no last on the final word
  localparam int err_missing_last_bit = 0;
  // last arrived before the buffers were full
  localparam int err_early_last_bit = 1;

endpackage

// File: src/awg_config_regs.sv
`timescale 1ns/10ps

module awg_config_regs (
  input logic dac_clk,
  input logic dma_reset,
  input logic [awg_dims_pkg::num_channels*awg_dims_pkg::depth_field_width-1:0] depth_data,
  input logic depth_valid,
  output logic depth_ready,
  input awg_ctrl_pkg::trigger_mode_t [awg_dims_pkg::num_channels-1:0] trig_cfg_data,
  input logic trig_cfg_valid,
  output logic trig_cfg_ready,
  input awg_dims_pkg::burst_count_t [awg_dims_pkg::num_channels-1:0] burst_len_data,
  input logic burst_len_valid,
  output logic burst_len_ready,
  input logic [1:0] start_stop_data,
  input logic start_stop_valid,
  output logic start_stop_ready,
  input logic sample_valid,
  input logic sample_last,
  output logic sample_ready,
  input logic load_complete,
  input logic player_busy,
  input logic burst_done,
  output awg_dims_pkg::buf_addr_t [awg_dims_pkg::num_channels-1:0] addr_max,
  output awg_dims_pkg::burst_count_t [awg_dims_pkg::num_channels-1:0] burst_max,
  output awg_ctrl_pkg::trigger_mode_t [awg_dims_pkg::num_channels-1:0] trig_mode,
  output awg_ctrl_pkg::load_state_t load_state,
  output logic start_pulse,
  output logic stop_pulse
);

  logic cfg_open;
  logic depth_fire;
  logic sample_fire;

  ////////////////////
  // ready generation
  ////////////////////

  // config only changes while nothing is loading or playing
  assign cfg_open = (load_state == awg_ctrl_pkg::load_idle) && !player_busy;
  assign depth_ready = cfg_open;
  assign trig_cfg_ready = cfg_open;
  assign burst_len_ready = cfg_open;
  assign sample_ready = load_state == awg_ctrl_pkg::load_accepting;
  // start/stop allowed as long as the buffers are not being written
  assign start_stop_ready = load_state != awg_ctrl_pkg::load_accepting;

  assign depth_fire = depth_valid && depth_ready;
  assign sample_fire = sample_valid && sample_ready;

  ////////////////////
  // load state machine
  ////////////////////

  always_ff @(posedge dac_clk) begin
    if (dma_reset) begin
      load_state <= awg_ctrl_pkg::load_idle;
    end else begin
      case (load_state)
        awg_ctrl_pkg::load_idle: begin
          if (depth_fire) begin
            load_state <= awg_ctrl_pkg::load_accepting;
          end
        end
        awg_ctrl_pkg::load_accepting: begin
          // close on the last word itself so no extra word slips in
          if (load_complete || (sample_fire && sample_last)) begin
            load_state <= awg_ctrl_pkg::load_blocking;
          end
        end
        awg_ctrl_pkg::load_blocking: begin
          if (stop_pulse || burst_done) begin
            load_state <= awg_ctrl_pkg::load_idle;
          end
        end
        default: load_state <= awg_ctrl_pkg::load_idle;
      endcase
    end
  end

  ////////////////////
  // config registers
  ////////////////////

  always_ff @(posedge dac_clk) begin
    if (dma_reset) begin
      addr_max <= '0;
      burst_max <= '0;
      trig_mode <= {awg_dims_pkg::num_channels{awg_ctrl_pkg::trig_off}};
    end else begin
      for (int ch = 0; ch < awg_dims_pkg::num_channels; ch++) begin
        // keep depth-1 and length-1 so the other blocks compare directly
        if (depth_fire) begin
          addr_max[ch] <= awg_dims_pkg::buf_addr_t'(
            depth_data[ch*awg_dims_pkg::depth_field_width +: awg_dims_pkg::depth_field_width]
            - 1'b1);
        end
        if (burst_len_valid && burst_len_ready) begin
          burst_max[ch] <= burst_len_data[ch] - 1'b1;
        end
      end
      if (trig_cfg_valid && trig_cfg_ready) begin
        trig_mode <= trig_cfg_data;
      end
    end
  end

  // start/stop word becomes single cycle pulses
  always_ff @(posedge dac_clk) begin
    if (dma_reset) begin
      start_pulse <= 1'b0;
      stop_pulse <= 1'b0;
    end else begin
      start_pulse <= start_stop_valid && start_stop_ready && start_stop_data[1];
      stop_pulse <= start_stop_valid && start_stop_ready && start_stop_data[0];
    end
  end

endmodule

// File: src/awg_buffer_writer.sv
`timescale 1ns/10ps

module awg_buffer_writer (
  input logic dac_clk,
  input logic dma_reset,
  input awg_dims_pkg::sample_word_t sample_data,
  input logic sample_fire,
  input logic sample_last,
  input logic depth_accept,
  input awg_ctrl_pkg::load_state_t load_state,
  input awg_dims_pkg::buf_addr_t [awg_dims_pkg::num_channels-1:0] addr_max,
  output logic wr_en,
  output awg_dims_pkg::channel_t wr_channel,
  output awg_dims_pkg::buf_addr_t wr_addr,
  output awg_dims_pkg::sample_word_t wr_word,
  output logic load_complete,
  output awg_ctrl_pkg::err_status_t status_data,
  output logic status_valid,
  input logic status_ready
);

  localparam awg_dims_pkg::channel_t last_channel =
    awg_dims_pkg::channel_t'(awg_dims_pkg::num_channels - 1);

  logic fire_q;
  logic last_q;
  logic [awg_dims_pkg::num_channels-1:0] chan_done;
  logic final_word;

  // accepted word is written one cycle later
  always_ff @(posedge dac_clk) begin
    wr_word <= sample_data;
    last_q <= sample_last;
    if (dma_reset) begin
      fire_q <= 1'b0;
    end else begin
      fire_q <= sample_fire;
    end
  end

  // a filled channel drops further writes
  assign wr_en = fire_q && !chan_done[wr_channel];
  assign final_word = (wr_channel == last_channel) && (wr_addr == addr_max[wr_channel]);
  assign load_complete = wr_en && (last_q || final_word);

  ////////////////////
  // write pointer
  ////////////////////

  always_ff @(posedge dac_clk) begin
    if (dma_reset) begin
      wr_addr <= '0;
      wr_channel <= '0;
      chan_done <= '0;
    end else if (load_state == awg_ctrl_pkg::load_idle) begin
      wr_addr <= '0;
      wr_channel <= '0;
      chan_done <= '0;
    end else if (wr_en) begin
      if (wr_addr == addr_max[wr_channel]) begin
        // end of this channel, step to the next
        wr_addr <= '0;
        chan_done[wr_channel] <= 1'b1;
        if (wr_channel == last_channel) begin
          wr_channel <= '0;
        end else begin
          wr_channel <= wr_channel + 1'b1;
        end
      end else begin
        wr_addr <= wr_addr + 1'b1;
      end
    end
  end

  ////////////////////
  // transfer status
  ////////////////////

  always_ff @(posedge dac_clk) begin
    if (dma_reset) begin
      status_data <= '0;
      status_valid <= 1'b0;
    end else if (depth_accept) begin
      // new load starts with a clean status
      status_data <= '0;
      status_valid <= 1'b0;
    end else begin
      if (status_valid && status_ready) begin
        status_data <= '0;
        status_valid <= 1'b0;
      end
      if (wr_en) begin
        if (final_word) begin
          // buffers full, last should be here
          status_data[awg_ctrl_pkg::err_missing_last_bit] <= !last_q;
          status_valid <= 1'b1;
        end else if (last_q) begin
          status_data[awg_ctrl_pkg::err_early_last_bit] <= 1'b1;
          status_valid <= 1'b1;
        end
      end
    end
  end

endmodule

// File: src/awg_wave_memory.sv
`timescale 1ns/10ps

module awg_wave_memory (
  input logic dac_clk,
  input logic wr_en,
  input awg_dims_pkg::channel_t wr_channel,
  input awg_dims_pkg::buf_addr_t wr_addr,
  input awg_dims_pkg::sample_word_t wr_word,
  input awg_dims_pkg::buf_addr_t [awg_dims_pkg::num_channels-1:0] rd_addr,
  output awg_dims_pkg::sample_word_t [awg_dims_pkg::num_channels-1:0] rd_word
);

  for (genvar ch = 0; ch < awg_dims_pkg::num_channels; ch++) begin : g_chan
    awg_dims_pkg::sample_word_t buffer [awg_dims_pkg::buffer_depth];
    // first read register, second is rd_word itself
    awg_dims_pkg::sample_word_t rd_stage;

    // single write port shared by all channels
    always_ff @(posedge dac_clk) begin
      if (wr_en && (wr_channel == awg_dims_pkg::channel_t'(ch))) begin
        buffer[wr_addr] <= wr_word;
      end
    end

    // every channel reads every cycle
    always_ff @(posedge dac_clk) begin
      rd_stage <= buffer[rd_addr[ch]];
      rd_word[ch] <= rd_stage;
    end
  end

endmodule

// File: src/awg_player.sv
`timescale 1ns/10ps

module awg_player (
  input logic dac_clk,
  input logic dma_reset,
  input logic start_pulse,
  input logic stop_pulse,
  input awg_dims_pkg::buf_addr_t [awg_dims_pkg::num_channels-1:0] addr_max,
  input awg_dims_pkg::burst_count_t [awg_dims_pkg::num_channels-1:0] burst_max,
  input awg_ctrl_pkg::trigger_mode_t [awg_dims_pkg::num_channels-1:0] trig_mode,
  output awg_dims_pkg::buf_addr_t [awg_dims_pkg::num_channels-1:0] rd_addr,
  input awg_dims_pkg::sample_word_t [awg_dims_pkg::num_channels-1:0] rd_word,
  output awg_dims_pkg::sample_word_t [awg_dims_pkg::num_channels-1:0] dac_data,
  output logic [awg_dims_pkg::num_channels-1:0] dac_trigger,
  output logic player_busy,
  output logic burst_done
);

  localparam int nch = awg_dims_pkg::num_channels;

  logic active;
  awg_dims_pkg::burst_count_t [nch-1:0] frame_cnt;
  logic [nch-1:0] chan_done;

  // per channel flags for the word currently addressed
  logic [nch-1:0] zero_now;
  logic [nch-1:0] trig_now;
  // two stages to line up with the memory read registers
  logic [1:0][nch-1:0] zero_pipe;
  logic [1:0][nch-1:0] trig_pipe;

  assign player_busy = active;
  assign burst_done = active && (&chan_done);

  ////////////////////
  // idle/active FSM
  ////////////////////

  always_ff @(posedge dac_clk) begin
    if (dma_reset) begin
      active <= 1'b0;
    end else if (stop_pulse || burst_done) begin
      active <= 1'b0;
    end else if (start_pulse) begin
      active <= 1'b1;
    end
  end

  ////////////////////
  // address and frame counters
  ////////////////////

  always_ff @(posedge dac_clk) begin
    if (dma_reset) begin
      rd_addr <= '0;
      frame_cnt <= '0;
      chan_done <= '0;
    end else if (!active) begin
      rd_addr <= '0;
      frame_cnt <= '0;
      chan_done <= '0;
    end else begin
      for (int ch = 0; ch < nch; ch++) begin
        // a finished channel holds where it is
        if (!chan_done[ch]) begin
          if (rd_addr[ch] == addr_max[ch]) begin
            rd_addr[ch] <= '0;
            if (frame_cnt[ch] == burst_max[ch]) begin
              frame_cnt[ch] <= '0;
              chan_done[ch] <= 1'b1;
            end else begin
              frame_cnt[ch] <= frame_cnt[ch] + 1'b1;
            end
          end else begin
            rd_addr[ch] <= rd_addr[ch] + 1'b1;
          end
        end
      end
    end
  end

  // trigger on the first word of a frame, per channel mode
  always_comb begin
    for (int ch = 0; ch < nch; ch++) begin
      zero_now[ch] = !active || chan_done[ch];
      trig_now[ch] = 1'b0;
      if (!zero_now[ch] && (rd_addr[ch] == '0)) begin
        if (trig_mode[ch] == awg_ctrl_pkg::trig_every_frame) begin
          trig_now[ch] = 1'b1;
        end
        if ((trig_mode[ch] == awg_ctrl_pkg::trig_burst_start) && (frame_cnt[ch] == '0)) begin
          trig_now[ch] = 1'b1;
        end
      end
    end
  end

  ////////////////////
  // output alignment
  ////////////////////

  // address cycle + 3 = dac_data cycle, for data and trigger alike
  always_ff @(posedge dac_clk) begin
    if (dma_reset) begin
      zero_pipe <= '1;
      trig_pipe <= '0;
      dac_trigger <= '0;
      dac_data <= '0;
    end else begin
      zero_pipe <= {zero_pipe[0], zero_now};
      trig_pipe <= {trig_pipe[0], trig_now};
      dac_trigger <= trig_pipe[1];
      for (int ch = 0; ch < nch; ch++) begin
        if (zero_pipe[1][ch]) begin
          dac_data[ch] <= '0;
        end else begin
          dac_data[ch] <= rd_word[ch];
        end
      end
    end
  end

endmodule

// File: src/awg_top.sv
`timescale 1ns/10ps

module awg_top (
  input logic dac_clk,
  input logic dma_reset,
  // configuration streams
  input logic [awg_dims_pkg::num_channels*awg_dims_pkg::depth_field_width-1:0] depth_data,
  input logic depth_valid,
  output logic depth_ready,
  input awg_ctrl_pkg::trigger_mode_t [awg_dims_pkg::num_channels-1:0] trig_cfg_data,
  input logic trig_cfg_valid,
  output logic trig_cfg_ready,
  input awg_dims_pkg::burst_count_t [awg_dims_pkg::num_channels-1:0] burst_len_data,
  input logic burst_len_valid,
  output logic burst_len_ready,
  input logic [1:0] start_stop_data,
  input logic start_stop_valid,
  output logic start_stop_ready,
  // waveform load stream
  input awg_dims_pkg::sample_word_t sample_data,
  input logic sample_valid,
  input logic sample_last,
  output logic sample_ready,
  // transfer status
  output awg_ctrl_pkg::err_status_t status_data,
  output logic status_valid,
  input logic status_ready,
  // dac side
  output awg_dims_pkg::sample_word_t [awg_dims_pkg::num_channels-1:0] dac_data,
  output logic [awg_dims_pkg::num_channels-1:0] dac_trigger
);

  // stored configuration
  awg_dims_pkg::buf_addr_t [awg_dims_pkg::num_channels-1:0] addr_max;
  awg_dims_pkg::burst_count_t [awg_dims_pkg::num_channels-1:0] burst_max;
  awg_ctrl_pkg::trigger_mode_t [awg_dims_pkg::num_channels-1:0] trig_mode;
  awg_ctrl_pkg::load_state_t load_state;
  logic start_pulse;
  logic stop_pulse;

  // handshakes seen by the writer
  logic sample_fire;
  logic depth_accept;

  // write port
  logic wr_en;
  awg_dims_pkg::channel_t wr_channel;
  awg_dims_pkg::buf_addr_t wr_addr;
  awg_dims_pkg::sample_word_t wr_word;
  logic load_complete;

  // read ports
  awg_dims_pkg::buf_addr_t [awg_dims_pkg::num_channels-1:0] rd_addr;
  awg_dims_pkg::sample_word_t [awg_dims_pkg::num_channels-1:0] rd_word;
  logic player_busy;
  logic burst_done;

  assign sample_fire = sample_valid && sample_ready;
  assign depth_accept = depth_valid && depth_ready;

  awg_config_regs config_regs_i (
    .dac_clk(dac_clk),
    .dma_reset(dma_reset),
    .depth_data(depth_data),
    .depth_valid(depth_valid),
    .depth_ready(depth_ready),
    .trig_cfg_data(trig_cfg_data),
    .trig_cfg_valid(trig_cfg_valid),
    .trig_cfg_ready(trig_cfg_ready),
    .burst_len_data(burst_len_data),
    .burst_len_valid(burst_len_valid),
    .burst_len_ready(burst_len_ready),
    .start_stop_data(start_stop_data),
    .start_stop_valid(start_stop_valid),
    .start_stop_ready(start_stop_ready),
    .sample_valid(sample_valid),
    .sample_last(sample_last),
    .sample_ready(sample_ready),
    .load_complete(load_complete),
    .player_busy(player_busy),
    .burst_done(burst_done),
    .addr_max(addr_max),
    .burst_max(burst_max),
    .trig_mode(trig_mode),
    .load_state(load_state),
    .start_pulse(start_pulse),
    .stop_pulse(stop_pulse)
  );

  awg_buffer_writer buffer_writer_i (
    .dac_clk(dac_clk),
    .dma_reset(dma_reset),
    .sample_data(sample_data),
    .sample_fire(sample_fire),
    .sample_last(sample_last),
    .depth_accept(depth_accept),
    .load_state(load_state),
    .addr_max(addr_max),
    .wr_en(wr_en),
    .wr_channel(wr_channel),
    .wr_addr(wr_addr),
    .wr_word(wr_word),
    .load_complete(load_complete),
    .status_data(status_data),
    .status_valid(status_valid),
    .status_ready(status_ready)
  );

  awg_wave_memory wave_memory_i (
    .dac_clk(dac_clk),
    .wr_en(wr_en),
    .wr_channel(wr_channel),
    .wr_addr(wr_addr),
    .wr_word(wr_word),
    .rd_addr(rd_addr),
    .rd_word(rd_word)
  );

  awg_player player_i (
    .dac_clk(dac_clk),
    .dma_reset(dma_reset),
    .start_pulse(start_pulse),
    .stop_pulse(stop_pulse),
    .addr_max(addr_max),
    .burst_max(burst_max),
    .trig_mode(trig_mode),
    .rd_addr(rd_addr),
    .rd_word(rd_word),
    .dac_data(dac_data),
    .dac_trigger(dac_trigger),
    .player_busy(player_busy),
    .burst_done(burst_done)
  );

endmodule

// File: sim/awg_asserts.sv
`timescale 1ns/10ps

module awg_config_asserts (
  input logic dac_clk,
  input logic dma_reset,
  input logic start_pulse,
  input logic stop_pulse,
  input logic sample_ready,
  input logic depth_ready,
  input awg_ctrl_pkg::load_state_t load_state
);

  // command pulses last exactly one cycle
  start_single: assert property (@(posedge dac_clk) disable iff (dma_reset)
    start_pulse |=> !start_pulse) else $error("start_pulse high two cycles");
  stop_single: assert property (@(posedge dac_clk) disable iff (dma_reset)
    stop_pulse |=> !stop_pulse) else $error("stop_pulse high two cycles");

  // loading and configuring never overlap
  ready_excl: assert property (@(posedge dac_clk) disable iff (dma_reset)
    !(sample_ready && depth_ready)) else $error("sample_ready and depth_ready both high");

  // blocking is only reached through accepting
  no_skip: assert property (@(posedge dac_clk) disable iff (dma_reset)
    (load_state == awg_ctrl_pkg::load_idle) |=> (load_state != awg_ctrl_pkg::load_blocking))
    else $error("load_state jumped from idle to blocking");

endmodule

bind awg_config_regs awg_config_asserts config_asserts_i (
  .dac_clk(dac_clk),
  .dma_reset(dma_reset),
  .start_pulse(start_pulse),
  .stop_pulse(stop_pulse),
  .sample_ready(sample_ready),
  .depth_ready(depth_ready),
  .load_state(load_state)
);

// File: sim/awg_tb.sv
`timescale 1ns/10ps

module awg_tb;

  localparam int nch = awg_dims_pkg::num_channels;
  localparam int dw = awg_dims_pkg::depth_field_width;
  localparam int ww = awg_dims_pkg::word_width;

  logic dac_clk = 1'b0;
  logic dma_reset;
  logic [nch*dw-1:0] depth_data;
  logic depth_valid;
  logic depth_ready;
  awg_ctrl_pkg::trigger_mode_t [nch-1:0] trig_cfg_data;
  logic trig_cfg_valid;
  logic trig_cfg_ready;
  awg_dims_pkg::burst_count_t [nch-1:0] burst_len_data;
  logic burst_len_valid;
  logic burst_len_ready;
  logic [1:0] start_stop_data;
  logic start_stop_valid;
  logic start_stop_ready;
  awg_dims_pkg::sample_word_t sample_data;
  logic sample_valid;
  logic sample_last;
  logic sample_ready;
  awg_ctrl_pkg::err_status_t status_data;
  logic status_valid;
  logic status_ready;
  awg_dims_pkg::sample_word_t [nch-1:0] dac_data;
  logic [nch-1:0] dac_trigger;

  // host side copy of what was loaded and configured
  logic [15:0] lfsr_state;
  awg_dims_pkg::sample_word_t wave [nch][awg_dims_pkg::buffer_depth];
  int cfg_depth [nch];
  int cfg_burst [nch];
  awg_ctrl_pkg::trigger_mode_t cfg_mode [nch];

  // comparing process state
  int idx [nch];
  logic check_on = 1'b0;
  int errors = 0;
  int tests_run = 0;
  int tests_failed = 0;
  int err_before;

  awg_top DUT (.*);

  always #20 dac_clk = ~dac_clk;

  ////////////////////
  // stimulus helpers
  ////////////////////

  // 16 bit fibonacci with taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic awg_dims_pkg::sample_word_t random_word();
    awg_dims_pkg::sample_word_t w;
    for (int i = 0; i < ww; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      w[i] = lfsr_state[0];
    end
    // odd low sample, so a real word is never zero
    w[0] = 1'b1;
    return w;
  endfunction

  // expected {trigger, word} for output number k of a channel
  function automatic logic [ww:0] expected_entry(int ch, int k);
    int a;
    logic trig;
    a = k % cfg_depth[ch];
    trig = (a == 0) && ((cfg_mode[ch] == awg_ctrl_pkg::trig_every_frame) ||
      ((cfg_mode[ch] == awg_ctrl_pkg::trig_burst_start) && (k < cfg_depth[ch])));
    return {trig, wave[ch][a]};
  endfunction

  task automatic tick();
    @(posedge dac_clk);
    #2;
  endtask

  task automatic abort_on_timeout(string what);
    $display("timeout while waiting for %s", what);
    $display("tests failed");
    $finish;
  endtask

  task automatic send_config(logic with_depth, int d0, int d1, int b0, int b1,
                             awg_ctrl_pkg::trigger_mode_t m0,
                             awg_ctrl_pkg::trigger_mode_t m1);
    int n;
    n = 0;
    if (with_depth) begin
      cfg_depth[0] = d0;
      cfg_depth[1] = d1;
    end
    cfg_burst[0] = b0;
    cfg_burst[1] = b1;
    cfg_mode[0] = m0;
    cfg_mode[1] = m1;
    depth_data[0 +: dw] = d0[dw-1:0];
    depth_data[dw +: dw] = d1[dw-1:0];
    burst_len_data[0] = b0[15:0];
    burst_len_data[1] = b1[15:0];
    trig_cfg_data[0] = m0;
    trig_cfg_data[1] = m1;
    depth_valid = with_depth;
    trig_cfg_valid = 1'b1;
    burst_len_valid = 1'b1;
    // all three readies follow the same rule
    while (!(trig_cfg_ready && burst_len_ready)) begin
      tick();
      n++;
      if (n > 200) abort_on_timeout("configuration ready");
    end
    tick();
    depth_valid = 1'b0;
    trig_cfg_valid = 1'b0;
    burst_len_valid = 1'b0;
  endtask

  task automatic send_cmd(logic [1:0] cmd);
    int n;
    n = 0;
    start_stop_data = cmd;
    start_stop_valid = 1'b1;
    while (!start_stop_ready) begin
      tick();
      n++;
      if (n > 200) abort_on_timeout("start_stop_ready");
    end
    tick();
    start_stop_valid = 1'b0;
  endtask

  // last_at is the word index that carries last, -1 for none
  task automatic load_words(int last_at);
    int n;
    int ch;
    int a;
    awg_dims_pkg::sample_word_t w;
    for (int i = 0; i < cfg_depth[0] + cfg_depth[1]; i++) begin
      ch = (i < cfg_depth[0]) ? 0 : 1;
      a = (ch == 0) ? i : i - cfg_depth[0];
      w = random_word();
      wave[ch][a] = w;
      sample_data = w;
      sample_last = (i == last_at);
      sample_valid = 1'b1;
      n = 0;
      while (!sample_ready) begin
        tick();
        n++;
        if (n > 200) abort_on_timeout("sample_ready");
      end
      tick();
      if (i == last_at) break;
    end
    sample_valid = 1'b0;
    sample_last = 1'b0;
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    while (!depth_ready) begin
      tick();
      n++;
      if (n > 2000) abort_on_timeout("player and loader to go idle");
    end
  endtask

  task automatic check_ready(logic cfg, logic smp, logic ss);
    if (depth_ready !== cfg) begin
      $display("Fail at %0t: depth_ready got %b expected %b", $time, depth_ready, cfg);
      errors++;
    end
    if (trig_cfg_ready !== cfg) begin
      $display("Fail at %0t: trig_cfg_ready got %b expected %b", $time,
               trig_cfg_ready, cfg);
      errors++;
    end
    if (burst_len_ready !== cfg) begin
      $display("Fail at %0t: burst_len_ready got %b expected %b", $time,
               burst_len_ready, cfg);
      errors++;
    end
    if (sample_ready !== smp) begin
      $display("Fail at %0t: sample_ready got %b expected %b", $time, sample_ready, smp);
      errors++;
    end
    if (start_stop_ready !== ss) begin
      $display("Fail at %0t: start_stop_ready got %b expected %b", $time,
               start_stop_ready, ss);
      errors++;
    end
  endtask

  task automatic check_status(awg_ctrl_pkg::err_status_t expected);
    int n;
    n = 0;
    while (!status_valid) begin
      tick();
      n++;
      if (n > 100) abort_on_timeout("status_valid");
    end
    if (status_data !== expected) begin
      $display("Fail at %0t: status_data got %b expected %b", $time, status_data, expected);
      errors++;
    end
    // status must hold while the host is not ready
    repeat (3) tick();
    if (!status_valid) begin
      $display("status valid dropped at %0t while ready was low", $time);
      errors++;
    end
    status_ready = 1'b1;
    tick();
    status_ready = 1'b0;
    if (status_valid) begin
      $display("status valid still high at %0t after it was read", $time);
      errors++;
    end
  endtask

  task automatic play_and_check();
    idx[0] = 0;
    idx[1] = 0;
    check_on = 1'b1;
    send_cmd(2'b10);
    repeat (2) tick();
    wait_idle();
    // let the read pipeline drain
    repeat (6) tick();
    for (int ch = 0; ch < nch; ch++) begin
      if (idx[ch] != cfg_depth[ch] * cfg_burst[ch]) begin
        $display("channel %0d gave %0d words, expected %0d", ch, idx[ch],
                 cfg_depth[ch] * cfg_burst[ch]);
        errors++;
      end
    end
    check_on = 1'b0;
  endtask

  task automatic finish_test(string name);
    tests_run++;
    if (errors > err_before) begin
      tests_failed++;
      $display("test %s: failed", name);
    end else begin
      $display("test %s: ok", name);
    end
    err_before = errors;
  endtask

  ////////////////////
  // comparing process
  ////////////////////

  // outputs change on the rising edge, look at them on the falling one
  always @(negedge dac_clk) begin
    logic [ww:0] exp_e;
    if (check_on) begin
      for (int ch = 0; ch < nch; ch++) begin
        if (dac_data[ch] != '0) begin
          if (idx[ch] >= cfg_depth[ch] * cfg_burst[ch]) begin
            $display("channel %0d output a word at %0t after its burst ended", ch, $time);
            errors++;
          end else begin
            exp_e = expected_entry(ch, idx[ch]);
            if (dac_data[ch] !== exp_e[ww-1:0]) begin
              $display("Fail at %0t: dac_data[%0d] got %h expected %h", $time, ch,
                       dac_data[ch], exp_e[ww-1:0]);
              errors++;
            end
            if (dac_trigger[ch] !== exp_e[ww]) begin
              $display("Fail at %0t: dac_trigger[%0d] got %b expected %b", $time, ch,
                       dac_trigger[ch], exp_e[ww]);
              errors++;
            end
          end
          idx[ch]++;
        end else if (dac_trigger[ch]) begin
          $display("Fail at %0t: dac_trigger[%0d] got 1 expected 0", $time, ch);
          errors++;
        end
      end
    end
  end

  ////////////////////
  // test sequence
  ////////////////////

  initial begin
    int n;
    dma_reset = 1'b1;
    depth_data = '0;
    depth_valid = 1'b0;
    trig_cfg_data = '0;
    trig_cfg_valid = 1'b0;
    burst_len_data = '0;
    burst_len_valid = 1'b0;
    start_stop_data = '0;
    start_stop_valid = 1'b0;
    sample_data = '0;
    sample_valid = 1'b0;
    sample_last = 1'b0;
    status_ready = 1'b0;
    lfsr_state = 16'd39;
    err_before = 0;
    repeat (10) @(posedge dac_clk);
    #2;
    dma_reset = 1'b0;
    tick();

    // depths 5 and 16, bursts 3 and 1
    send_config(1'b1, 5, 16, 3, 1, awg_ctrl_pkg::trig_every_frame,
                awg_ctrl_pkg::trig_burst_start);
    load_words(20);
    check_status(2'b00);
    play_and_check();
    finish_test("1 load and play");

    send_config(1'b0, 0, 0, 3, 2, awg_ctrl_pkg::trig_burst_start,
                awg_ctrl_pkg::trig_every_frame);
    play_and_check();
    send_config(1'b0, 0, 0, 1, 1, awg_ctrl_pkg::trig_off, awg_ctrl_pkg::trig_off);
    play_and_check();
    finish_test("2 trigger modes");

    send_config(1'b0, 0, 0, 3, 3, awg_ctrl_pkg::trig_every_frame,
                awg_ctrl_pkg::trig_every_frame);
    idx[0] = 0;
    idx[1] = 0;
    check_on = 1'b1;
    send_cmd(2'b10);
    repeat (12) tick();
    send_cmd(2'b01);
    n = 0;
    while (dac_data != '0) begin
      tick();
      n++;
      if (n > 4) begin
        $display("dac_data not zero within 4 cycles of the stop command");
        errors++;
        break;
      end
    end
    wait_idle();
    check_on = 1'b0;
    finish_test("3 stop mid-burst");

    // early last on word 3, then a load with no last at all
    send_config(1'b1, 5, 16, 1, 1, awg_ctrl_pkg::trig_off, awg_ctrl_pkg::trig_off);
    load_words(3);
    check_status(2'b10);
    send_cmd(2'b01);
    wait_idle();
    send_config(1'b1, 5, 16, 1, 1, awg_ctrl_pkg::trig_off, awg_ctrl_pkg::trig_off);
    load_words(-1);
    check_status(2'b01);
    send_cmd(2'b01);
    wait_idle();
    finish_test("4 transfer status");

    check_ready(1'b1, 1'b0, 1'b1);
    send_config(1'b1, 4, 6, 2, 2, awg_ctrl_pkg::trig_off, awg_ctrl_pkg::trig_off);
    check_ready(1'b0, 1'b1, 1'b0);
    load_words(9);
    check_status(2'b00);
    send_cmd(2'b10);
    repeat (3) tick();
    check_ready(1'b0, 1'b0, 1'b1);
    wait_idle();
    check_ready(1'b1, 1'b0, 1'b1);
    // playback started from idle keeps configuration closed too
    send_cmd(2'b10);
    repeat (3) tick();
    check_ready(1'b0, 1'b0, 1'b1);
    wait_idle();
    check_ready(1'b1, 1'b0, 1'b1);
    finish_test("5 ready rules");

    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// File: awg_top.f
src/awg_dims_pkg.sv
src/awg_ctrl_pkg.sv
src/awg_config_regs.sv
src/awg_buffer_writer.sv
src/awg_wave_memory.sv
src/awg_player.sv
src/awg_top.sv
sim/awg_asserts.sv
sim/awg_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module awg_tb -f awg_top.f -o awg_sim

output=$(./obj_dir/awg_sim)
echo "$output"

echo "$output" | grep -q "^all tests passed$"
